// ==== Makefile ====
SRCS := $(wildcard src/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_bpu: verilog.f $(SRCS)
	verilator --binary --timing --top-module tb_bpu -f verilog.f

run: obj_dir/Vtb_bpu verification/bpu_trace.txt
	./obj_dir/Vtb_bpu > sim.log 2>&1 || true
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/bpu.sv ====
/*
 * Branch prediction unit, prediction is combinational on curr_pc_i.
 * Taken needs both a taken gshare counter and a BTB hit.
 * The BTB learns only from mispredicts; gshare learns from every resolution.
 */

`default_nettype none

module bpu #(
    parameter int unsigned     HLEN     = fetch_pkg::HLEN,
    parameter int unsigned     BTB_BITS = fetch_pkg::BTB_BITS,
    parameter fetch_pkg::c2b_t INIT_C2B = fetch_pkg::INIT_C2B
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  core_pkg::xlen_t        curr_pc_i,
    input  logic                   comm_res_valid_i,
    input  fetch_pkg::resolution_t comm_res_i,
    output fetch_pkg::prediction_t pred_o
);

    import core_pkg::*;
    import fetch_pkg::*;

    logic        gshare_taken;
    logic        btb_hit;
    logic        btb_update;
    logic        btb_del_entry;
    btb_target_t btb_target;

    // Direction predictor
    gshare #(
        .HLEN     (HLEN),
        .INIT_C2B (INIT_C2B)
    ) u_gshare (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .curr_pc_i   (curr_pc_i),
        .res_valid_i (comm_res_valid_i),
        .res_i       (comm_res_i),
        .taken_o     (gshare_taken)
    );

    // Target predictor
    btb #(
        .BTB_BITS (BTB_BITS)
    ) u_btb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .valid_i     (btb_update),
        .del_entry_i (btb_del_entry),
        .curr_pc_i   (curr_pc_i),
        .res_i       (comm_res_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // BTB changes only on a mispredict
    // Taken installs the target, not taken drops the entry
    assign btb_update    = comm_res_valid_i & comm_res_i.mispredict;
    assign btb_del_entry = comm_res_i.mispredict & ~comm_res_i.taken;

    // Prediction echoes the PC so fetch can match it
    assign pred_o.pc     = curr_pc_i;
    assign pred_o.taken  = gshare_taken & btb_hit;
    assign pred_o.target = {btb_target, {OFFSET{1'b0}}};

endmodule

`default_nettype wire

// ==== src/btb.sv ====
/*
 * Direct-mapped branch target buffer, read asynchronously.
 * Index is PC[OFFSET +: BTB_BITS], the tag is all remaining upper bits.
 * Flush clears every valid bit and outranks an update in the same cycle.
 */

`default_nettype none

module btb #(
    parameter int unsigned BTB_BITS = fetch_pkg::BTB_BITS
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    input  logic                   del_entry_i,
    input  core_pkg::xlen_t        curr_pc_i,
    input  fetch_pkg::resolution_t res_i,
    output logic                   hit_o,
    output fetch_pkg::btb_target_t target_o
);

    import core_pkg::*;
    import fetch_pkg::*;

    localparam int unsigned ENTRIES = 1 << BTB_BITS;

    // Tag covers everything above the index
    localparam int unsigned TAG_W = XLEN - OFFSET - BTB_BITS;

    typedef logic [BTB_BITS-1:0] idx_t;
    typedef logic [TAG_W-1:0]    tag_t;

    // Per-entry state
    logic [ENTRIES-1:0] valid_q;
    tag_t               tag_q    [ENTRIES];
    btb_target_t        target_q [ENTRIES];

    // Lookup side
    idx_t rd_idx;
    tag_t rd_tag;

    // Update side
    idx_t        wr_idx;
    tag_t        wr_tag;
    btb_target_t wr_target;

    assign rd_idx = curr_pc_i[OFFSET +: BTB_BITS];
    assign rd_tag = curr_pc_i[XLEN-1 -: TAG_W];

    assign wr_idx    = res_i.pc[OFFSET +: BTB_BITS];
    assign wr_tag    = res_i.pc[XLEN-1 -: TAG_W];
    assign wr_target = res_i.target[XLEN-1:OFFSET];

    // Hit needs a live entry with a matching tag
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // Target is read even on a miss
    // Only meaningful together with hit_o
    assign target_o = target_q[rd_idx];

    // Valid bits
    // Install sets the bit, delete clears it
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q <= '0;
        end else if (valid_i) begin
            valid_q[wr_idx] <= ~del_entry_i;
        end
    end

    // Tag and target payload
    // Delete leaves the old payload behind the cleared valid bit
    always_ff @(posedge clk_i) begin
        if (valid_i && !del_entry_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target;
        end
    end

endmodule

`default_nettype wire

// ==== src/core_pkg.sv ====
/*
 * Core-wide widths for an RV32 core without compressed instructions.
 * Instructions are word aligned, so the low OFFSET bits of a PC are zero.
 */

`default_nettype none

package core_pkg;

    // Data and address width of the core
    localparam int unsigned XLEN = 32;

    // Low PC bits that are always zero for word-aligned instructions
    // Tables index above these bits and never store them
    localparam int unsigned OFFSET = 2;

    // PC or branch target
    typedef logic [XLEN-1:0] xlen_t;

endpackage

`default_nettype wire

// ==== src/fetch_pkg.sv ====
/*
 * Branch predictor sizes and types for the fetch stage.
 * HLEN and BTB_BITS are only defaults; the modules take them as parameters.
 * Widths here follow the core widths of core_pkg.
 */

`default_nettype none

package fetch_pkg;

    // Global history length, also the gshare index width
    localparam int unsigned HLEN = 4;

    // BTB index width, 16 entries by default
    localparam int unsigned BTB_BITS = 4;

    // Two-bit saturating counter
    // Upper bit gives the predicted direction
    typedef enum logic [1:0] {
        SNT = 2'b00,    // strongly not taken
        WNT = 2'b01,    // weakly not taken
        WT  = 2'b10,    // weakly taken
        ST  = 2'b11     // strongly taken
    } c2b_t;

    // Counter value after reset
    localparam c2b_t INIT_C2B = WNT;

    // Branch target without its always-zero low bits
    typedef logic [core_pkg::XLEN-core_pkg::OFFSET-1:0] btb_target_t;

    // Prediction for the current fetch PC
    // Target is only meaningful when taken is set
    typedef struct packed {
        core_pkg::xlen_t pc;
        logic            taken;
        core_pkg::xlen_t target;
    } prediction_t;

    // Resolution of a committed branch
    // Mispredict is set when the earlier prediction was wrong
    typedef struct packed {
        core_pkg::xlen_t pc;
        core_pkg::xlen_t target;
        logic            taken;
        logic            mispredict;
    } resolution_t;

endpackage

`default_nettype wire

// ==== src/gshare.sv ====
/*
 * Gshare direction predictor with an asynchronous counter read.
 * The history is updated from committed branches only; there is no
 * speculative history and no repair. Flush clears the history, not the counters.
 */

`default_nettype none

module gshare #(
    parameter int unsigned     HLEN     = fetch_pkg::HLEN,
    parameter fetch_pkg::c2b_t INIT_C2B = fetch_pkg::INIT_C2B
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  core_pkg::xlen_t        curr_pc_i,
    input  logic                   res_valid_i,
    input  fetch_pkg::resolution_t res_i,
    output logic                   taken_o
);

    import core_pkg::*;
    import fetch_pkg::*;

    // One counter per history/PC combination
    localparam int unsigned ENTRIES = 1 << HLEN;

    // Global history, newest outcome in bit 0
    logic [HLEN-1:0] ghr_q;

    // Pattern history table
    c2b_t            pht_q [ENTRIES];

    logic [HLEN-1:0] rd_idx;
    logic [HLEN-1:0] wr_idx;
    c2b_t            rd_cnt;
    c2b_t            wr_cnt;
    c2b_t            upd_cnt;

    // Lookup index from the fetch PC
    assign rd_idx = curr_pc_i[OFFSET +: HLEN] ^ ghr_q;

    // Update index uses the history from before this edge
    assign wr_idx = res_i.pc[OFFSET +: HLEN] ^ ghr_q;

    // Same-cycle update is not forwarded, lookup sees the old counter
    assign rd_cnt  = pht_q[rd_idx];
    assign taken_o = rd_cnt[1];

    assign wr_cnt = pht_q[wr_idx];

    // Saturating step toward the resolved outcome
    always_comb begin
        upd_cnt = wr_cnt;
        unique case (wr_cnt)
            SNT:     upd_cnt = res_i.taken ? WNT : SNT;
            WNT:     upd_cnt = res_i.taken ? WT  : SNT;
            WT:      upd_cnt = res_i.taken ? ST  : WNT;
            ST:      upd_cnt = res_i.taken ? ST  : WT;
            default: upd_cnt = INIT_C2B;
        endcase
    end

    // History register
    // Flush wins over a shift in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            ghr_q <= '0;
        end else if (res_valid_i) begin
            ghr_q <= (ghr_q << 1) | HLEN'(res_i.taken);
        end
    end

    // Counter table
    // Counters keep training through a flush
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht_q[i] <= INIT_C2B;
            end
        end else if (res_valid_i) begin
            pht_q[wr_idx] <= upd_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== verification/bpu_checker.sv ====
/*
 * Compares pred_o with the expectations of the current trace line.
 * Samples on the rising edge, inputs settled at the falling edge before.
 * Target is only compared when a taken prediction is expected.
 */

`default_nettype none

module bpu_checker (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   check_i,
    input  logic                   done_i,
    input  logic [15:0]            test_i,
    input  core_pkg::xlen_t        exp_pc_i,
    input  logic                   exp_taken_i,
    input  core_pkg::xlen_t        exp_target_i,
    input  fetch_pkg::prediction_t pred_i,
    output logic                   finished_o,
    output int                     errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    // Running totals
    int          tests;
    int          checks;
    int          test_checks;
    int          test_errors;
    logic [15:0] cur_test;
    bit          started;

    // One summary line per finished test
    task automatic close_test();
        $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        tests++;
    endtask

    task automatic report_mismatch(input string what, input xlen_t got, input xlen_t want);
        $display("error at %0t: test %0d pc %h %s is %h, expected %h",
                 $time, test_i, exp_pc_i, what, got, want);
        test_errors++;
        errors_o++;
    endtask

    task automatic compare_prediction();
        checks++;
        test_checks++;
        if (pred_i.pc !== exp_pc_i) begin
            report_mismatch("pc", pred_i.pc, exp_pc_i);
        end
        if (pred_i.taken !== exp_taken_i) begin
            report_mismatch("taken", xlen_t'(pred_i.taken), xlen_t'(exp_taken_i));
        end
        // Target is don't care on a not-taken prediction
        if (exp_taken_i && pred_i.target !== exp_target_i) begin
            report_mismatch("target", pred_i.target, exp_target_i);
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            tests       = 0;
            checks      = 0;
            test_checks = 0;
            test_errors = 0;
            cur_test    = '0;
            started     = 1'b0;
            errors_o    = 0;
            finished_o  = 1'b0;
        end else if (!finished_o) begin
            if (check_i) begin
                // New test number closes the previous test
                if (started && test_i != cur_test) begin
                    close_test();
                end
                if (!started || test_i != cur_test) begin
                    cur_test    = test_i;
                    test_checks = 0;
                    test_errors = 0;
                    started     = 1'b1;
                end
                compare_prediction();
            end
            if (done_i) begin
                if (started) begin
                    close_test();
                end
                $display("%0d tests, %0d checks, %0d errors", tests, checks, errors_o);
                finished_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/bpu_trace.txt ====
# test flush pc rvalid rpc rtarget rtaken rmispredict exp_taken exp_target
# Hex except test; HLEN 4 and BTB_BITS 4, all counters weakly not taken after reset
# Test 1: fresh tables predict not taken
1 0 00001000 0 00000000 00000000 0 0 0 00000000
1 0 00001004 0 00000000 00000000 0 0 0 00000000
1 0 0000203c 0 00000000 00000000 0 0 0 00000000
1 0 80000010 0 00000000 00000000 0 0 0 00000000
1 0 00001010 0 00000000 00000000 0 0 0 00000000
# Test 2: install at counter 4, then walk history back to zero with not-taken
2 0 00001000 1 00001010 00002000 1 1 0 00000000
2 0 00001010 1 00003020 00000000 0 0 0 00000000
2 0 00001010 1 00003020 00000000 0 0 0 00000000
2 0 00001010 1 00003020 00000000 0 0 0 00000000
2 0 00001010 1 00003020 00000000 0 0 0 00000000
2 0 00001010 0 00000000 00000000 0 0 1 00002000
2 0 00005010 0 00000000 00000000 0 0 0 00000000
# Test 3: install at index 6, counter 7 saturates low then steps once
3 0 00000100 1 00001018 00004000 1 1 0 00000000
3 0 00000100 1 00001018 00000000 0 0 0 00000000
3 0 00000100 1 00001014 00000000 0 0 0 00000000
3 0 00000100 1 0000100c 00000000 0 0 0 00000000
3 0 00000100 1 0000103c 00000000 1 0 0 00000000
3 0 00001018 0 00000000 00000000 0 0 0 00000000
# Test 4: delete index 4, tag mismatch at index 6
4 0 00000100 1 00001010 00000000 0 1 0 00000000
4 0 00001010 0 00000000 00000000 0 0 0 00000000
4 0 00005018 0 00000000 00000000 0 0 0 00000000
4 0 00001018 0 00000000 00000000 0 0 1 00004000
# Test 5: flush, the flush cycle still sees the old entry
5 1 00001018 0 00000000 00000000 0 0 1 00004000
5 0 00001018 0 00000000 00000000 0 0 0 00000000
5 0 00001010 0 00000000 00000000 0 0 0 00000000
5 0 00000100 1 00001014 00006000 1 1 0 00000000
5 0 00001014 0 00000000 00000000 0 0 1 00006000
# Test 6: correct prediction trains gshare only
6 0 00000100 1 00001038 00008000 1 0 0 00000000
6 0 00001030 0 00000000 00000000 0 0 0 00000000
6 0 00001038 0 00000000 00000000 0 0 0 00000000
6 0 00001014 0 00000000 00000000 0 0 1 00006000

// ==== verification/tb_bpu.sv ====
/*
 * Testbench top for the branch prediction unit.
 * Run from the project root, the trace is read from verification/bpu_trace.txt.
 * Each trace line is one clock cycle, inputs change on the falling edge.
 */

`default_nettype none

module tb_bpu;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;
    import fetch_pkg::*;

    // Cycle limits for every wait loop
    localparam int RESET_LIMIT = 20;
    localparam int TRACE_LIMIT = 1000;
    localparam int DONE_LIMIT  = 20;
    localparam int RESET_CYCLES = 2;

    logic        clk;
    logic        rst;
    logic        flush;
    xlen_t       curr_pc;
    logic        res_valid;
    resolution_t res;
    prediction_t pred;

    // Expectations handed to the checker
    logic        chk_valid;
    logic [15:0] chk_test;
    logic        exp_taken;
    xlen_t       exp_target;
    xlen_t       exp_pc;
    logic        trace_done;
    logic        finished;
    int          errors;

    bit          run_ok;

    bpu dut_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .flush_i          (flush),
        .curr_pc_i        (curr_pc),
        .comm_res_valid_i (res_valid),
        .comm_res_i       (res),
        .pred_o           (pred)
    );

    bpu_checker checker_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .check_i      (chk_valid),
        .done_i       (trace_done),
        .test_i       (chk_test),
        .exp_pc_i     (exp_pc),
        .exp_taken_i  (exp_taken),
        .exp_target_i (exp_target),
        .pred_i       (pred),
        .finished_o   (finished),
        .errors_o     (errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Hold reset for a fixed number of rising edges, release on a falling edge
    task automatic apply_reset(output bit ok);
        int cycles;
        int waited;
        cycles = 0;
        waited = 0;
        while (cycles < RESET_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        // Checker must have cleared its state while reset was high
        while (finished !== 1'b0 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        ok = (finished === 1'b0);
        if (!ok) begin
            $display("checker not cleared within %0d cycles of reset", RESET_LIMIT);
        end
        @(negedge clk);
        rst = 1'b0;
    endtask

    // One trace line per cycle, comment and blank lines are skipped
    task automatic play_trace(output bit ok);
        int          fd;
        int          code;
        int          fields;
        int          reads;
        int          applied;
        int          t;
        string       line;
        logic [31:0] fl;
        logic [31:0] pc;
        logic [31:0] rv;
        logic [31:0] rpc;
        logic [31:0] tg;
        logic [31:0] tk;
        logic [31:0] mp;
        logic [31:0] et;
        logic [31:0] etg;
        ok = 1'b1;
        reads = 0;
        applied = 0;
        fd = $fopen("verification/bpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verification/bpu_trace.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && reads < TRACE_LIMIT) begin
                reads++;
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != 8'h23) begin
                    fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h",
                                     t, fl, pc, rv, rpc, tg, tk, mp, et, etg);
                    if (fields == 10) begin
                        @(negedge clk);
                        flush          = fl[0];
                        curr_pc        = pc;
                        res_valid      = rv[0];
                        res.pc         = rpc;
                        res.target     = tg;
                        res.taken      = tk[0];
                        res.mispredict = mp[0];
                        chk_valid      = 1'b1;
                        chk_test       = t[15:0];
                        exp_pc         = pc;
                        exp_taken      = et[0];
                        exp_target     = etg;
                        applied++;
                    end
                end
            end
            if (reads >= TRACE_LIMIT) begin
                $display("trace still not at its end after %0d lines", TRACE_LIMIT);
                ok = 1'b0;
            end
            if (applied == 0) begin
                $display("trace file held no stimulus lines");
                ok = 1'b0;
            end
            $fclose(fd);
        end
        // Back to idle and tell the checker the trace is over
        @(negedge clk);
        flush      = 1'b0;
        res_valid  = 1'b0;
        res        = '0;
        chk_valid  = 1'b0;
        trace_done = 1'b1;
    endtask

    task automatic wait_for_checker(output bit ok);
        int cycles;
        cycles = 0;
        while (!finished && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = finished;
        if (!finished) begin
            $display("checker did not finish within %0d cycles after the trace", DONE_LIMIT);
        end
    endtask

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        curr_pc    = '0;
        res_valid  = 1'b0;
        res        = '0;
        chk_valid  = 1'b0;
        chk_test   = '0;
        exp_taken  = 1'b0;
        exp_target = '0;
        exp_pc     = '0;
        trace_done = 1'b0;

        apply_reset(run_ok);
        if (run_ok) begin
            play_trace(run_ok);
        end
        if (run_ok) begin
            wait_for_checker(run_ok);
        end

        if (run_ok && errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/core_pkg.sv
src/fetch_pkg.sv
src/gshare.sv
src/btb.sv
src/bpu.sv
verification/bpu_checker.sv
verification/tb_bpu.sv
